/* hdl/fxp_pkg.sv */
// data word widths for the butterfly datapath
// sign-magnitude / two's-complement word union
// output saturation limit and product scaling

package fxp_pkg;

    // ****************************************
    // word widths
    // ****************************************

    // one real or imaginary component
    parameter int DATA_W = 17;
    // magnitude field, sign bit sits above it
    parameter int MAG_W = DATA_W - 1;

    // ****************************************
    // data word, two views of the same bits
    // ****************************************

    // sm view: sign bit plus unsigned magnitude, the port format
    // tc view: signed value used inside the pipeline
    // both views are 17 bits wide
    typedef union packed {
        struct packed {
            // 1 = negative
            logic             sign;
            logic [MAG_W-1:0] mag;
        } sm;
        logic signed [DATA_W-1:0] tc;
    } sm_word_t;

    // ****************************************
    // arithmetic limits
    // ****************************************

    // largest magnitude an output word may carry
    // all ones in the mag field
    parameter int SAT_MAX = 2**MAG_W - 1;

    // twiddles are Q1.7
    // a product carries 7 fraction bits that get dropped
    parameter int PROD_SHIFT = 7;

endpackage

/* hdl/twiddle_pkg.sv */
// rotation index width and twiddle component width
// first-quadrant cosine magnitude table for W256

package twiddle_pkg;

    // ****************************************
    // index and component widths
    // ****************************************

    // k selects W256^k, k = 0..127
    parameter int ROT_W = 7;
    // signed component, 1 sign bit and 7 magnitude bits
    parameter int TW_W = 8;
    // k = 64 is the -j point
    parameter int QUARTER = 64;

    // ****************************************
    // quarter-wave magnitude table
    // ****************************************

    // entry i is round(127 * cos(pi * i / 128)), i = 0..64
    // the other three quadrants are folded onto this one
    // sin(pi*k/128) reads entry |64 - k|
    parameter logic [TW_W-2:0] TW_MAG [0:QUARTER] = '{
        // i = 0..7
        7'd127, 7'd127, 7'd127, 7'd127, 7'd126, 7'd126, 7'd126, 7'd125,
        // i = 8..15
        7'd125, 7'd124, 7'd123, 7'd122, 7'd122, 7'd121, 7'd120, 7'd118,
        // i = 16..23, entry 16 is cos(pi/8)
        7'd117, 7'd116, 7'd115, 7'd113, 7'd112, 7'd111, 7'd109, 7'd107,
        // i = 24..31
        7'd106, 7'd104, 7'd102, 7'd100, 7'd98,  7'd96,  7'd94,  7'd92,
        // i = 32..39, entry 32 is cos(pi/4)
        7'd90,  7'd88,  7'd85,  7'd83,  7'd81,  7'd78,  7'd76,  7'd73,
        // i = 40..47
        7'd71,  7'd68,  7'd65,  7'd63,  7'd60,  7'd57,  7'd54,  7'd51,
        // i = 48..55
        7'd49,  7'd46,  7'd43,  7'd40,  7'd37,  7'd34,  7'd31,  7'd28,
        // i = 56..63
        7'd25,  7'd22,  7'd19,  7'd16,  7'd12,  7'd9,   7'd6,   7'd3,
        // i = 64, cos(pi/2)
        7'd0
    };

endpackage

/* hdl/twiddle_rom.sv */
// twiddle lookup for W256^k
// folds k onto the first-quadrant table
// returns signed Q1.7 real and imaginary parts

module twiddle_rom
(
    input  logic [twiddle_pkg::ROT_W-1:0]       rotation,
    output logic signed [twiddle_pkg::TW_W-1:0] tw_re,
    output logic signed [twiddle_pkg::TW_W-1:0] tw_im
);

    // k in 64..127, cosine is negative there
    logic                                upper_half;
    // table indices after folding
    logic [twiddle_pkg::ROT_W-1:0]       re_idx;
    logic [twiddle_pkg::ROT_W-1:0]       im_idx;
    // magnitudes with a zero sign bit added
    logic signed [twiddle_pkg::TW_W-1:0] re_mag;
    logic signed [twiddle_pkg::TW_W-1:0] im_mag;
    // squared length of the folded twiddle
    int                                  tw_len_sq;

    // ****************************************
    // quadrant folding
    // ****************************************

    assign upper_half = (rotation >= twiddle_pkg::QUARTER);

    // cos(pi*k/128) = -cos(pi*(128-k)/128) for k >= 64
    // k = 64 lands on entry 64, which is zero
    assign re_idx = upper_half ? twiddle_pkg::ROT_W'(2 * twiddle_pkg::QUARTER - rotation)
                               : rotation;

    // sin(pi*k/128) = cos(pi*|64-k|/128)
    // k = 0 reads entry 64, so the sine is zero there
    assign im_idx = upper_half ? twiddle_pkg::ROT_W'(rotation - twiddle_pkg::QUARTER)
                               : twiddle_pkg::ROT_W'(twiddle_pkg::QUARTER - rotation);

    // ****************************************
    // table read and sign
    // ****************************************

    assign re_mag = {1'b0, twiddle_pkg::TW_MAG[re_idx]};
    assign im_mag = {1'b0, twiddle_pkg::TW_MAG[im_idx]};

    // real part flips sign in the second half turn
    assign tw_re = upper_half ? -re_mag : re_mag;

    // W = cos - j*sin, and sin >= 0 for the whole half circle
    assign tw_im = -im_mag;

    assign tw_len_sq = int'(tw_re) * int'(tw_re) + int'(tw_im) * int'(tw_im);

    // each component is rounded by at most 0.5
    // so |W|^2 stays within 181 of 127^2 when both indices fold together
    // a mismatched re/im fold lands far off the circle
    always_comb
    begin
        assert final ((tw_len_sq >= 127 * 127 - 181) && (tw_len_sq <= 127 * 127 + 181))
            else $error("twiddle_rom: |W|^2 = %0d off the circle for k = %0d",
                        tw_len_sq, rotation);
    end

endmodule

/* hdl/bf_input_stage.sv */
// pipeline stage 1 of the butterfly
// sign-magnitude to two's-complement conversion of x0 and x1
// twiddle lookup, registered with the data and the valid strobe

module bf_input_stage
(
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                in_valid,
    input  fxp_pkg::sm_word_t                   x0_re,
    input  fxp_pkg::sm_word_t                   x0_im,
    input  fxp_pkg::sm_word_t                   x1_re,
    input  fxp_pkg::sm_word_t                   x1_im,
    input  logic [twiddle_pkg::ROT_W-1:0]       rotation,
    output logic                                s1_valid,
    output fxp_pkg::sm_word_t                   a0_re,
    output fxp_pkg::sm_word_t                   a0_im,
    output fxp_pkg::sm_word_t                   a1_re,
    output fxp_pkg::sm_word_t                   a1_im,
    output logic signed [twiddle_pkg::TW_W-1:0] tw_re,
    output logic signed [twiddle_pkg::TW_W-1:0] tw_im
);

    // twiddle straight from the table, before the register
    logic signed [twiddle_pkg::TW_W-1:0] rom_re;
    logic signed [twiddle_pkg::TW_W-1:0] rom_im;

    // read through the sm view, write through the tc view
    // negative zero negates to plain zero
    function automatic fxp_pkg::sm_word_t sm_to_tc(input fxp_pkg::sm_word_t w);
        fxp_pkg::sm_word_t              r;
        logic signed [fxp_pkg::DATA_W-1:0] pos;
        pos  = {1'b0, w.sm.mag};
        r.tc = w.sm.sign ? -pos : pos;
        return r;
    endfunction

    // combinational lookup, settles within this stage
    twiddle_rom u_twiddle_rom
    (
        .rotation (rotation),
        .tw_re    (rom_re),
        .tw_im    (rom_im)
    );

    // ****************************************
    // stage 1 registers
    // ****************************************

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            s1_valid <= 1'b0;
            a0_re    <= '0;
            a0_im    <= '0;
            a1_re    <= '0;
            a1_im    <= '0;
            tw_re    <= '0;
            tw_im    <= '0;
        end
        else
        begin
            s1_valid <= in_valid;
            // data loads every cycle, qualified by s1_valid downstream
            a0_re    <= sm_to_tc(x0_re);
            a0_im    <= sm_to_tc(x0_im);
            a1_re    <= sm_to_tc(x1_re);
            a1_im    <= sm_to_tc(x1_im);
            tw_re    <= rom_re;
            tw_im    <= rom_im;
        end
    end

endmodule

/* hdl/complex_rotator.sv */
// pipeline stage 2 of the butterfly
// complex multiply of x1 by the twiddle from four real products
// Q1.7 scaling by arithmetic shift, x0 delayed alongside

module complex_rotator
(
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic                                s1_valid,
    input  fxp_pkg::sm_word_t                   a0_re,
    input  fxp_pkg::sm_word_t                   a0_im,
    input  fxp_pkg::sm_word_t                   a1_re,
    input  fxp_pkg::sm_word_t                   a1_im,
    input  logic signed [twiddle_pkg::TW_W-1:0] tw_re,
    input  logic signed [twiddle_pkg::TW_W-1:0] tw_im,
    output logic                                s2_valid,
    output fxp_pkg::sm_word_t                   d0_re,
    output fxp_pkg::sm_word_t                   d0_im,
    output logic signed [fxp_pkg::DATA_W:0]     t_re,
    output logic signed [fxp_pkg::DATA_W:0]     t_im
);

    // 17 x 8 signed product
    localparam int PROD_W = fxp_pkg::DATA_W + twiddle_pkg::TW_W;
    // sum or difference of two products
    localparam int SUM_W = PROD_W + 1;
    // rotated component after scaling
    localparam int T_W = fxp_pkg::DATA_W + 1;

    // the four real products
    logic signed [PROD_W-1:0] p_rr;
    logic signed [PROD_W-1:0] p_ii;
    logic signed [PROD_W-1:0] p_ri;
    logic signed [PROD_W-1:0] p_ir;
    // full-width rotated components, Q.7
    logic signed [SUM_W-1:0]  re_full;
    logic signed [SUM_W-1:0]  im_full;
    // after dropping the fraction bits
    logic signed [SUM_W-1:0]  re_scaled;
    logic signed [SUM_W-1:0]  im_scaled;

    // ****************************************
    // complex multiply
    // ****************************************

    assign p_rr = a1_re.tc * tw_re;
    assign p_ii = a1_im.tc * tw_im;
    assign p_ri = a1_re.tc * tw_im;
    assign p_ir = a1_im.tc * tw_re;

    // (a + jb)(c + jd) = (ac - bd) + j(ad + bc)
    // no rounding before the shift, full width kept
    assign re_full = p_rr - p_ii;
    assign im_full = p_ri + p_ir;

    // arithmetic shift, so this is a floor
    assign re_scaled = re_full >>> fxp_pkg::PROD_SHIFT;
    assign im_scaled = im_full >>> fxp_pkg::PROD_SHIFT;

    // ****************************************
    // stage 2 registers
    // ****************************************

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            s2_valid <= 1'b0;
            d0_re    <= '0;
            d0_im    <= '0;
            t_re     <= '0;
            t_im     <= '0;
        end
        else
        begin
            s2_valid <= s1_valid;
            // x0 only waits here for t
            d0_re    <= a0_re;
            d0_im    <= a0_im;
            t_re     <= re_scaled[T_W-1:0];
            t_im     <= im_scaled[T_W-1:0];
        end
    end

    // |x1| up to 65535*sqrt(2) times a table gain near 1
    // keeps both parts well inside 18 bits
    assert property (@(posedge clk) disable iff (!arst_n)
        s1_valid |-> ($signed(re_scaled[T_W-1:0]) == re_scaled) &&
                     ($signed(im_scaled[T_W-1:0]) == im_scaled))
        else $error("complex_rotator: rotated x1 overflows %0d bits", T_W);

endmodule

/* hdl/bf_output_stage.sv */
// pipeline stage 3 of the butterfly
// y0 = x0 + t and y1 = x0 - t, clamped to the output range
// conversion back to sign-magnitude and output registers

module bf_output_stage
(
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            s2_valid,
    input  fxp_pkg::sm_word_t               d0_re,
    input  fxp_pkg::sm_word_t               d0_im,
    input  logic signed [fxp_pkg::DATA_W:0] t_re,
    input  logic signed [fxp_pkg::DATA_W:0] t_im,
    output logic                            out_valid,
    output fxp_pkg::sm_word_t               y0_re,
    output fxp_pkg::sm_word_t               y0_im,
    output fxp_pkg::sm_word_t               y1_re,
    output fxp_pkg::sm_word_t               y1_im
);

    // 17-bit x0 plus 18-bit t needs one more bit
    localparam int SUM_W = fxp_pkg::DATA_W + 2;

    // raw butterfly results, integer scale
    // t already had its Q1.7 fraction dropped by PROD_SHIFT
    logic signed [SUM_W-1:0] y0_re_sum;
    logic signed [SUM_W-1:0] y0_im_sum;
    logic signed [SUM_W-1:0] y1_re_sum;
    logic signed [SUM_W-1:0] y1_im_sum;

    // clamp to +-SAT_MAX, then split into sign and magnitude
    // zero always leaves with a plus sign
    function automatic fxp_pkg::sm_word_t sat_to_sm(input logic signed [SUM_W-1:0] v);
        fxp_pkg::sm_word_t       r;
        logic signed [SUM_W-1:0] lim;
        logic signed [SUM_W-1:0] mag;
        if (v > fxp_pkg::SAT_MAX)
            lim = SUM_W'(fxp_pkg::SAT_MAX);
        else if (v < -fxp_pkg::SAT_MAX)
            lim = -SUM_W'(fxp_pkg::SAT_MAX);
        else
            lim = v;
        mag        = (lim < 0) ? -lim : lim;
        r.sm.sign  = (lim < 0);
        r.sm.mag   = mag[fxp_pkg::MAG_W-1:0];
        return r;
    endfunction

    // true for a sign bit set over a zero magnitude
    function automatic logic neg_zero(input fxp_pkg::sm_word_t w);
        return w.sm.sign && (w.sm.mag == '0);
    endfunction

    // ****************************************
    // butterfly add and subtract
    // ****************************************

    assign y0_re_sum = d0_re.tc + t_re;
    assign y0_im_sum = d0_im.tc + t_im;
    assign y1_re_sum = d0_re.tc - t_re;
    assign y1_im_sum = d0_im.tc - t_im;

    // output registers
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            out_valid <= 1'b0;
            y0_re     <= '0;
            y0_im     <= '0;
            y1_re     <= '0;
            y1_im     <= '0;
        end
        else
        begin
            out_valid <= s2_valid;
            y0_re     <= sat_to_sm(y0_re_sum);
            y0_im     <= sat_to_sm(y0_im_sum);
            y1_re     <= sat_to_sm(y1_re_sum);
            y1_im     <= sat_to_sm(y1_im_sum);
        end
    end

    // negative zero must never reach the outputs
    // covers input -0 as well as results that clamp or cancel to zero
    assert property (@(posedge clk) disable iff (!arst_n)
        out_valid |-> !(neg_zero(y0_re) || neg_zero(y0_im) ||
                        neg_zero(y1_re) || neg_zero(y1_im)))
        else $error("bf_output_stage: negative zero on a valid output");

endmodule

/* hdl/butterfly2.sv */
// radix-2 butterfly for a 256-point FFT, top level
// three register stages: input conversion, rotation, add/subtract
// latency 3 cycles, one item per cycle

module butterfly2
(
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          in_valid,
    input  fxp_pkg::sm_word_t             x0_re,
    input  fxp_pkg::sm_word_t             x0_im,
    input  fxp_pkg::sm_word_t             x1_re,
    input  fxp_pkg::sm_word_t             x1_im,
    input  logic [twiddle_pkg::ROT_W-1:0] rotation,
    output logic                          out_valid,
    output fxp_pkg::sm_word_t             y0_re,
    output fxp_pkg::sm_word_t             y0_im,
    output fxp_pkg::sm_word_t             y1_re,
    output fxp_pkg::sm_word_t             y1_im
);

    // stage 1 to stage 2, two's-complement words and twiddle
    logic                                s1_valid;
    fxp_pkg::sm_word_t                   a0_re;
    fxp_pkg::sm_word_t                   a0_im;
    fxp_pkg::sm_word_t                   a1_re;
    fxp_pkg::sm_word_t                   a1_im;
    logic signed [twiddle_pkg::TW_W-1:0] tw_re;
    logic signed [twiddle_pkg::TW_W-1:0] tw_im;

    // stage 2 to stage 3, delayed x0 and rotated x1
    logic                                s2_valid;
    fxp_pkg::sm_word_t                   d0_re;
    fxp_pkg::sm_word_t                   d0_im;
    logic signed [fxp_pkg::DATA_W:0]     t_re;
    logic signed [fxp_pkg::DATA_W:0]     t_im;

    // ****************************************
    // pipeline stages
    // ****************************************

    bf_input_stage u_bf_input_stage
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_valid (in_valid),
        .x0_re    (x0_re),
        .x0_im    (x0_im),
        .x1_re    (x1_re),
        .x1_im    (x1_im),
        .rotation (rotation),
        .s1_valid (s1_valid),
        .a0_re    (a0_re),
        .a0_im    (a0_im),
        .a1_re    (a1_re),
        .a1_im    (a1_im),
        .tw_re    (tw_re),
        .tw_im    (tw_im)
    );

    complex_rotator u_complex_rotator
    (
        .clk      (clk),
        .arst_n   (arst_n),
        .s1_valid (s1_valid),
        .a0_re    (a0_re),
        .a0_im    (a0_im),
        .a1_re    (a1_re),
        .a1_im    (a1_im),
        .tw_re    (tw_re),
        .tw_im    (tw_im),
        .s2_valid (s2_valid),
        .d0_re    (d0_re),
        .d0_im    (d0_im),
        .t_re     (t_re),
        .t_im     (t_im)
    );

    bf_output_stage u_bf_output_stage
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .s2_valid  (s2_valid),
        .d0_re     (d0_re),
        .d0_im     (d0_im),
        .t_re      (t_re),
        .t_im      (t_im),
        .out_valid (out_valid),
        .y0_re     (y0_re),
        .y0_im     (y0_im),
        .y1_re     (y1_re),
        .y1_im     (y1_im)
    );

endmodule

/* testbench/tb_butterfly2.sv */
// testbench for the radix-2 FFT butterfly
// LFSR stimulus, floating-point twiddle reference model
// expected-result queue checked against the DUT on every falling edge

module tb_butterfly2;

    timeunit 1ns;
    timeprecision 1ps;

    // ****************************************
    // run length and cycle limit
    // ****************************************

    localparam int RESET_CYCLES = 4;
    localparam int GAP_ITEMS = 64;
    // hand-picked 12, sweep 128, gapped 64, saturation 16, negative zero 6
    localparam int N_ITEMS = 12 + 128 + GAP_ITEMS + 16 + 6;
    // up to 3 idle cycles per gapped item, plus the final drain
    localparam int GAP_CYCLES = GAP_ITEMS * 3 + 8;
    localparam int CYCLE_LIMIT = RESET_CYCLES + N_ITEMS + GAP_CYCLES + 20;
    localparam real PI = 3.14159265358979;

    logic              clk = 1'b0;
    logic              arst_n;
    logic              in_valid;
    fxp_pkg::sm_word_t x0_re;
    fxp_pkg::sm_word_t x0_im;
    fxp_pkg::sm_word_t x1_re;
    fxp_pkg::sm_word_t x1_im;
    logic [6:0]        rotation;
    logic              out_valid;
    fxp_pkg::sm_word_t y0_re;
    fxp_pkg::sm_word_t y0_im;
    fxp_pkg::sm_word_t y1_re;
    fxp_pkg::sm_word_t y1_im;

    // expected {y0_re, y0_im, y1_re, y1_im} and the cycle it is due
    logic [67:0] exp_q[$];
    int          due_q[$];
    int          cycle_cnt = 0;
    logic [15:0] lfsr_state = 16'd18;

    butterfly2 u_butterfly2
    (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .x0_re     (x0_re),
        .x0_im     (x0_im),
        .x1_re     (x1_re),
        .x1_im     (x1_im),
        .rotation  (rotation),
        .out_valid (out_valid),
        .y0_re     (y0_re),
        .y0_im     (y0_im),
        .y1_re     (y1_re),
        .y1_im     (y1_im)
    );

    // 4 ns period
    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // ****************************************
    // helpers and reference model
    // ****************************************

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1);
    endtask

    // 16-bit Galois LFSR, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic lsb;
        lsb = s[0];
        s = s >> 1;
        if (lsb)
            s = s ^ 16'hB400;
        return s;
    endfunction

    // one LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    function automatic longint sm_value(input logic [16:0] w);
        return w[16] ? -longint'(w[15:0]) : longint'(w[15:0]);
    endfunction

    // clamp to +-SAT_MAX, zero always positive
    function automatic logic [16:0] to_sm(input longint v);
        longint lim;
        lim = v;
        if (lim > fxp_pkg::SAT_MAX)
            lim = fxp_pkg::SAT_MAX;
        if (lim < -fxp_pkg::SAT_MAX)
            lim = -fxp_pkg::SAT_MAX;
        if (lim < 0)
            return {1'b1, 16'(-lim)};
        return {1'b0, 16'(lim)};
    endfunction

    // round half away from zero
    function automatic longint round_q7(input real x);
        if (x >= 0.0)
            return $rtoi(x + 0.5);
        return -$rtoi(-x + 0.5);
    endfunction

    function automatic logic [67:0] ref_butterfly(input logic [16:0] x0r, x0i, x1r, x1i,
                                                  input int k);
        longint wr;
        longint wi;
        longint tr;
        longint ti;
        // W = cos - j*sin, both scaled by 127
        wr = round_q7(127.0 * $cos(PI * k / 128.0));
        wi = -round_q7(127.0 * $sin(PI * k / 128.0));
        // floor of the Q1.7 product
        tr = (sm_value(x1r) * wr - sm_value(x1i) * wi) >>> fxp_pkg::PROD_SHIFT;
        ti = (sm_value(x1r) * wi + sm_value(x1i) * wr) >>> fxp_pkg::PROD_SHIFT;
        return {to_sm(sm_value(x0r) + tr), to_sm(sm_value(x0i) + ti),
                to_sm(sm_value(x0r) - tr), to_sm(sm_value(x0i) - ti)};
    endfunction

    // ****************************************
    // stimulus tasks
    // ****************************************

    task automatic drive_item(input logic [16:0] x0r, x0i, x1r, x1i, input logic [6:0] k);
        @(posedge clk);
        in_valid <= 1'b1;
        x0_re    <= x0r;
        x0_im    <= x0i;
        x1_re    <= x1r;
        x1_im    <= x1i;
        rotation <= k;
        exp_q.push_back(ref_butterfly(x0r, x0i, x1r, x1i, int'(k)));
        // sampled on the next edge, out 3 edges later
        due_q.push_back(cycle_cnt + 4);
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic drive_random(input logic [6:0] k);
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        logic [31:0] w3;
        take_bits(17, w0);
        take_bits(17, w1);
        take_bits(17, w2);
        take_bits(17, w3);
        drive_item(w0[16:0], w1[16:0], w2[16:0], w3[16:0], k);
    endtask

    task automatic compare_word(input string name, input logic [16:0] got, exp);
        assert (got === exp)
        else
            stop_with_error($sformatf("ERR %s got 0x%05h expected 0x%05h", name, got, exp));
    endtask

    // ****************************************
    // checker
    // ****************************************

    always @(negedge clk)
    begin : check_outputs
        logic [67:0] exp_word;
        if (!arst_n)
        begin
            assert (out_valid === 1'b0)
            else
                stop_with_error("out_valid high while reset is asserted");
        end
        else if (out_valid === 1'b1)
        begin
            assert (exp_q.size() != 0)
            else
                stop_with_error("out_valid high with no input pending");
            assert (due_q[0] == cycle_cnt)
            else
                stop_with_error("result arrived at the wrong cycle");
            exp_word = exp_q.pop_front();
            void'(due_q.pop_front());
            compare_word("y0_re", y0_re, exp_word[67:51]);
            compare_word("y0_im", y0_im, exp_word[50:34]);
            compare_word("y1_re", y1_re, exp_word[33:17]);
            compare_word("y1_im", y1_im, exp_word[16:0]);
        end
        else if (due_q.size() != 0)
        begin
            // a result not seen on its due cycle is lost
            assert (due_q[0] > cycle_cnt)
            else
                stop_with_error("out_valid missing on the cycle a result was due");
        end
    end

    always @(negedge clk)
    begin
        if (cycle_cnt > CYCLE_LIMIT)
            stop_with_error("run did not finish within the cycle limit");
    end

    // ****************************************
    // test sequence
    // ****************************************

    initial
    begin : stimulus
        logic [31:0] gap;
        logic [31:0] rnd_k;
        int          hand_k [4];
        int          sat_k [4];
        hand_k = '{0, 32, 64, 96};
        sat_k = '{0, 16, 64, 100};
        arst_n   <= 1'b0;
        in_valid <= 1'b0;
        x0_re    <= '0;
        x0_im    <= '0;
        x1_re    <= '0;
        x1_im    <= '0;
        rotation <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        arst_n <= 1'b1;
        idle_cycle();

        // one k per quadrant boundary, x1 = 0 included
        foreach (hand_k[i])
        begin
            drive_item(to_sm(1000), to_sm(-2000), to_sm(3000), to_sm(4000), hand_k[i]);
            drive_item(to_sm(-500), to_sm(700), to_sm(0), to_sm(0), hand_k[i]);
            drive_item(to_sm(12345), to_sm(-6789), to_sm(-40000), to_sm(25000), hand_k[i]);
        end
        idle_cycle();

        // every rotation, back to back
        for (int k = 0; k < 128; k++)
            drive_random(7'(k));
        idle_cycle();

        // random idle gaps between items
        for (int i = 0; i < GAP_ITEMS; i++)
        begin
            take_bits(2, gap);
            repeat (gap) idle_cycle();
            take_bits(7, rnd_k);
            drive_random(rnd_k[6:0]);
        end
        idle_cycle();

        // full-scale words, all sign mixes
        foreach (sat_k[i])
        begin
            drive_item(to_sm(65535), to_sm(65535), to_sm(65535), to_sm(-65535), sat_k[i]);
            drive_item(to_sm(-65535), to_sm(-65535), to_sm(-65535), to_sm(65535), sat_k[i]);
            drive_item(to_sm(65535), to_sm(-65535), to_sm(65535), to_sm(65535), sat_k[i]);
            drive_item(to_sm(-65535), to_sm(65535), to_sm(-65535), to_sm(-65535), sat_k[i]);
        end
        idle_cycle();

        // -0 on the inputs, and a difference that cancels to zero
        drive_item(17'h10000, 17'h10000, 17'h10000, 17'h10000, 7'd0);
        drive_item(17'h10000, 17'h10000, 17'h10000, 17'h10000, 7'd37);
        drive_item(17'h10000, to_sm(5), 17'h10000, to_sm(300), 7'd64);
        drive_item(to_sm(100), 17'h10000, 17'h10000, to_sm(100), 7'd96);
        drive_item(to_sm(-254), 17'h10000, to_sm(-256), 17'h10000, 7'd0);
        drive_item(to_sm(0), to_sm(0), to_sm(0), to_sm(0), 7'd37);

        // pipeline is 3 deep, leave room to drain
        idle_cycle();
        repeat (5) @(posedge clk);

        if (exp_q.size() == 0)
        begin
            $display("all tests passed");
            $finish;
        end
        else
            stop_with_error("results still pending at the end of the run");
    end

endmodule

/* filelist.f */
hdl/fxp_pkg.sv
hdl/twiddle_pkg.sv
hdl/twiddle_rom.sv
hdl/bf_input_stage.sv
hdl/complex_rotator.sv
hdl/bf_output_stage.sv
hdl/butterfly2.sv
testbench/tb_butterfly2.sv
